//--- cpu_pkg.sv
// memory subsystem shared types
// bus widths, load/store ops, request and response records
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;

    // byte count minus one, so 0 = byte, 1 = half, 3 = word
    typedef logic [1:0]  len_t;

    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } ls_op_e;

    // address bits 17:16 of the io window
    localparam logic [1:0] IO_SEL = 2'd3;

    typedef struct packed {
        logic   en;
        addr_t  pc;
    } fetch_req_t;

    // store data sits in the low bytes of wdata
    typedef struct packed {
        logic   en;
        ls_op_e op;
        addr_t  addr;
        data_t  wdata;
    } ls_req_t;

    typedef struct packed {
        logic   done;
        data_t  data;
    } word_rsp_t;

    typedef struct packed {
        logic   start;
        logic   is_write;
        logic   is_fetch;
        addr_t  addr;
        len_t   len;
        data_t  wdata;
    } grant_t;

    function automatic logic op_is_store(input ls_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    function automatic len_t op_len(input ls_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd3;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- mem_sched.sv
// memory request scheduler
// load/store over fetch, one grant per request, clr and io-full hold-off
`timescale 1ns/1ns
`default_nettype none

module mem_sched #(
    parameter int IO_LSB = 16
) (
    input  logic                clk_in,
    input  logic                arst_n,
    input  logic                rdy_in,
    input  logic                clr,
    input  logic                io_buffer_full,
    input  cpu_pkg::fetch_req_t fetch_req,
    input  cpu_pkg::ls_req_t    ls_req,
    input  logic                busy,
    output cpu_pkg::grant_t     grant,
    output cpu_pkg::ls_op_e     grant_op
);

    logic            start_q;
    logic            pending;
    logic            is_write_q;
    logic            is_fetch_q;
    cpu_pkg::addr_t  addr_q;
    cpu_pkg::len_t   len_q;
    cpu_pkg::data_t  wdata_q;
    cpu_pkg::ls_op_e op_q;

    logic            ls_store;
    logic            ls_io_wait;
    logic            take_ls;
    logic            take_fetch;
    logic            issue;

    // io store must wait for room in the uart buffer
    assign ls_store   = cpu_pkg::op_is_store(ls_req.op);
    assign ls_io_wait = ls_store && io_buffer_full &&
                        (ls_req.addr[IO_LSB +: 2] == cpu_pkg::IO_SEL);

    // a blocked load/store still keeps fetch off the bus
    assign take_ls    = ls_req.en && !ls_io_wait;
    assign take_fetch = !ls_req.en && fetch_req.en && !clr;
    assign issue      = !pending && !busy && (take_ls || take_fetch);

    assign grant = '{start:    start_q,
                     is_write: is_write_q,
                     is_fetch: is_fetch_q,
                     addr:     addr_q,
                     len:      len_q,
                     wdata:    wdata_q};
    assign grant_op = op_q;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            start_q    <= 1'b0;
            pending    <= 1'b0;
            is_write_q <= 1'b0;
            is_fetch_q <= 1'b0;
        end else if (rdy_in) begin
            start_q <= issue;
            if (issue) begin
                pending    <= 1'b1;
                is_write_q <= take_ls && ls_store;
                is_fetch_q <= !take_ls;
            end else if (busy || (clr && is_fetch_q)) begin
                // sequencer took it, or a fetch was dropped before starting
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && issue) begin
            if (take_ls) begin
                addr_q  <= ls_req.addr;
                len_q   <= cpu_pkg::op_len(ls_req.op);
                wdata_q <= ls_req.wdata;
                op_q    <= ls_req.op;
            end else begin
                addr_q  <= fetch_req.pc;
                len_q   <= 2'd3;
                wdata_q <= '0;
                op_q    <= cpu_pkg::LW;
            end
        end
    end

    // sequencer must be idle whenever a new access is handed over
    a_no_start_busy: assert property (
        @(posedge clk_in) disable iff (!arst_n) grant.start |-> !busy
    );

endmodule

`default_nettype wire

//--- byte_seq.sv
// byte sequencer for the 8-bit memory bus
// walks one granted access byte by byte, gathers read bytes little-endian
`timescale 1ns/1ns
`default_nettype none

module byte_seq (
    input  logic               clk_in,
    input  logic               arst_n,
    input  logic               rdy_in,
    input  logic               clr,
    input  cpu_pkg::grant_t    grant,
    input  cpu_pkg::byte_t     mem_din,
    output cpu_pkg::byte_t     mem_dout,
    output cpu_pkg::addr_t     mem_a,
    output logic               mem_wr,
    output logic               busy,
    output cpu_pkg::word_rsp_t raw_rsp,
    output logic               raw_is_fetch
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_ADDR,
        P_TAIL,
        P_DONE
    } phase_e;

    phase_e         phase;
    cpu_pkg::len_t  cnt;
    cpu_pkg::len_t  len_q;
    logic           is_write_q;
    logic           is_fetch_q;
    logic           done_q;
    cpu_pkg::data_t data_q;
    cpu_pkg::data_t sh_q;
    logic           stall_q;
    cpu_pkg::byte_t din_hold;

    cpu_pkg::byte_t din_eff;
    cpu_pkg::data_t sh_next;
    cpu_pkg::data_t rd_word;
    logic           last;
    logic           abort;
    logic           accept;

    assign busy         = (phase != P_IDLE);
    assign raw_is_fetch = is_fetch_q;
    assign raw_rsp      = '{done: done_q, data: data_q};

    assign last   = (cnt == len_q);
    assign abort  = clr && is_fetch_q;
    assign accept = grant.start && !(clr && grant.is_fetch);

    // after a freeze, mem_din may already show the next byte,
    // so use the byte seen in the first frozen cycle
    assign din_eff = stall_q ? din_hold : mem_din;

    // one shift register serves both directions
    // reads shift bytes in at the top, writes shift bytes out at the bottom
    assign sh_next = {(is_write_q ? 8'h00 : din_eff), sh_q[31:8]};

    // short reads end up in the upper lanes
    assign rd_word = sh_next >> {2'd3 - len_q, 3'b000};

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= !rdy_in;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!stall_q) begin
            din_hold <= mem_din;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            phase      <= P_IDLE;
            cnt        <= '0;
            mem_a      <= '0;
            mem_wr     <= 1'b0;
            done_q     <= 1'b0;
            is_write_q <= 1'b0;
            is_fetch_q <= 1'b0;
        end else if (rdy_in) begin
            case (phase)
                P_IDLE: begin
                    if (accept) begin
                        phase      <= P_ADDR;
                        cnt        <= '0;
                        mem_a      <= grant.addr;
                        mem_wr     <= grant.is_write;
                        is_write_q <= grant.is_write;
                        is_fetch_q <= grant.is_fetch;
                    end
                end
                P_ADDR: begin
                    if (abort) begin
                        phase  <= P_IDLE;
                        mem_wr <= 1'b0;
                    end else if (last) begin
                        mem_wr <= 1'b0;
                        if (is_write_q) begin
                            phase  <= P_DONE;
                            done_q <= 1'b1;
                        end else begin
                            // last read byte still to come back
                            phase <= P_TAIL;
                        end
                    end else begin
                        cnt   <= cnt + 2'd1;
                        mem_a <= mem_a + 32'd1;
                    end
                end
                P_TAIL: begin
                    if (abort) begin
                        phase <= P_IDLE;
                    end else begin
                        phase  <= P_DONE;
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    phase  <= P_IDLE;
                    done_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (phase == P_IDLE && accept) begin
                len_q    <= grant.len;
                mem_dout <= grant.wdata[7:0];
                sh_q     <= grant.is_write ? {8'h00, grant.wdata[31:8]} : '0;
            end else if (phase == P_ADDR) begin
                if (is_write_q && !last) begin
                    mem_dout <= sh_q[7:0];
                    sh_q     <= sh_next;
                end else if (!is_write_q && cnt != 2'd0) begin
                    // byte cnt-1 is on mem_din now
                    sh_q <= sh_next;
                end
            end else if (phase == P_TAIL) begin
                data_q <= rd_word;
            end
        end
    end

    a_wr_in_busy: assert property (
        @(posedge clk_in) disable iff (!arst_n) mem_wr |-> busy
    );

    a_cnt_range: assert property (
        @(posedge clk_in) disable iff (!arst_n) busy |-> (cnt <= len_q)
    );

endmodule

`default_nettype wire

//--- load_align.sv
// response steering and load extension
// sign/zero-extends load data by op, sends done to fetch or load/store
`timescale 1ns/1ns
`default_nettype none

module load_align (
    input  logic               clk_in,
    input  logic               arst_n,
    input  cpu_pkg::word_rsp_t raw_rsp,
    input  logic               raw_is_fetch,
    input  cpu_pkg::ls_op_e    grant_op,
    input  cpu_pkg::grant_t    grant,
    output cpu_pkg::word_rsp_t fetch_rsp,
    output cpu_pkg::word_rsp_t ls_rsp
);

    cpu_pkg::ls_op_e op_q;
    cpu_pkg::data_t  ext;

    // op of the access now on the bus
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            op_q <= cpu_pkg::LW;
        end else if (grant.start) begin
            op_q <= grant_op;
        end
    end

    always_comb begin
        case (op_q)
            cpu_pkg::LB: begin
                ext = {{24{raw_rsp.data[7]}}, raw_rsp.data[7:0]};
            end
            cpu_pkg::LH: begin
                ext = {{16{raw_rsp.data[15]}}, raw_rsp.data[15:0]};
            end
            cpu_pkg::LBU: begin
                ext = {24'h000000, raw_rsp.data[7:0]};
            end
            cpu_pkg::LHU: begin
                ext = {16'h0000, raw_rsp.data[15:0]};
            end
            cpu_pkg::LW: begin
                ext = raw_rsp.data;
            end
            default: begin
                // stores return nothing
                ext = '0;
            end
        endcase
    end

    // fetch words go out as read
    assign fetch_rsp = '{done: raw_rsp.done && raw_is_fetch,
                         data: raw_rsp.data};
    assign ls_rsp    = '{done: raw_rsp.done && !raw_is_fetch,
                         data: ext};

endmodule

`default_nettype wire

//--- memctrl.sv
// memory controller top
// scheduler, byte sequencer and load aligner on one byte-wide bus
`timescale 1ns/1ns
`default_nettype none

module memctrl #(
    parameter int IO_LSB = 16
) (
    input  logic                clk_in,
    input  logic                arst_n,
    input  logic                rdy_in,
    input  logic                clr,
    input  logic                io_buffer_full,
    input  cpu_pkg::byte_t      mem_din,
    output cpu_pkg::byte_t      mem_dout,
    output cpu_pkg::addr_t      mem_a,
    output logic                mem_wr,
    input  cpu_pkg::fetch_req_t fetch_req,
    input  cpu_pkg::ls_req_t    ls_req,
    output cpu_pkg::word_rsp_t  fetch_rsp,
    output cpu_pkg::word_rsp_t  ls_rsp
);

    cpu_pkg::grant_t    grant;
    cpu_pkg::ls_op_e    grant_op;
    logic               busy;
    cpu_pkg::word_rsp_t raw_rsp;
    logic               raw_is_fetch;

    mem_sched #(
        .IO_LSB         (IO_LSB)
    ) i_sched (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .rdy_in         (rdy_in),
        .clr            (clr),
        .io_buffer_full (io_buffer_full),
        .fetch_req      (fetch_req),
        .ls_req         (ls_req),
        .busy           (busy),
        .grant          (grant),
        .grant_op       (grant_op)
    );

    byte_seq i_seq (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .rdy_in         (rdy_in),
        .clr            (clr),
        .grant          (grant),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .busy           (busy),
        .raw_rsp        (raw_rsp),
        .raw_is_fetch   (raw_is_fetch)
    );

    load_align i_align (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .raw_rsp        (raw_rsp),
        .raw_is_fetch   (raw_is_fetch),
        .grant_op       (grant_op),
        .grant          (grant),
        .fetch_rsp      (fetch_rsp),
        .ls_rsp         (ls_rsp)
    );

endmodule

`default_nettype wire

//--- tb_memctrl.sv
// memory controller testbench
// byte RAM model, case file driven checks, freeze and clr scenarios
`timescale 1ns/1ns
`default_nettype none

module tb_memctrl;

    logic                clk_in;
    logic                arst_n;
    logic                rdy_in;
    logic                clr;
    logic                io_buffer_full;
    cpu_pkg::byte_t      mem_din;
    cpu_pkg::byte_t      mem_dout;
    cpu_pkg::addr_t      mem_a;
    logic                mem_wr;
    cpu_pkg::fetch_req_t fetch_req;
    cpu_pkg::ls_req_t    ls_req;
    cpu_pkg::word_rsp_t  fetch_rsp;
    cpu_pkg::word_rsp_t  ls_rsp;

    logic [7:0]  ram [0:131071];
    int          wr_count = 0;
    int          errors = 0;
    int          ncases = 0;
    bit          cases_loaded = 1'b0;
    logic [31:0] lfsr = 32'd32;

    int          c_kind  [0:63];
    logic [2:0]  c_op    [0:63];
    logic [31:0] c_addr  [0:63];
    logic [31:0] c_wdata [0:63];
    logic [31:0] c_pc    [0:63];
    logic [31:0] c_exl   [0:63];
    logic [31:0] c_exf   [0:63];

    memctrl #(
        .IO_LSB         (16)
    ) i_dut (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .rdy_in         (rdy_in),
        .clr            (clr),
        .io_buffer_full (io_buffer_full),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .fetch_req      (fetch_req),
        .ls_req         (ls_req),
        .fetch_rsp      (fetch_rsp),
        .ls_rsp         (ls_rsp)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    // byte RAM answering one cycle after the address
    always @(posedge clk_in) begin
        mem_din <= ram[mem_a[16:0]];
        if (mem_wr) begin
            ram[mem_a[16:0]] <= mem_dout;
            if (rdy_in) begin
                wr_count <= wr_count + 1;
            end
        end
    end

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic bit lfsr_bit();
        bit fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int byte_count(input cpu_pkg::ls_op_e op);
        case (op)
            cpu_pkg::LB, cpu_pkg::LBU, cpu_pkg::SB: return 1;
            cpu_pkg::LH, cpu_pkg::LHU, cpu_pkg::SH: return 2;
            default:                                return 4;
        endcase
    endfunction

    function automatic bit is_store_op(input cpu_pkg::ls_op_e op);
        return (op == cpu_pkg::SB) || (op == cpu_pkg::SH) || (op == cpu_pkg::SW);
    endfunction

    task automatic check_rsp(input string name, input cpu_pkg::word_rsp_t got,
                             input cpu_pkg::word_rsp_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t got,
                              input cpu_pkg::addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input cpu_pkg::byte_t got,
                              input cpu_pkg::byte_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic fail(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic freeze_step(inout int lows);
        bit b;
        b = lfsr_bit();
        rdy_in <= b;
        if (!b) begin
            lows++;
        end
    endtask

    // one fetch or load/store on an idle bus with optional random rdy_in drops
    task automatic single_access(input bit fetch, input cpu_pkg::ls_op_e op,
                                 input cpu_pkg::addr_t addr, input cpu_pkg::data_t wdata,
                                 input bit freeze, input cpu_pkg::data_t exp);
        int                 n;
        int                 i;
        int                 lows;
        int                 lat;
        int                 w0;
        bit                 wr;
        bit                 seen;
        cpu_pkg::word_rsp_t rsp;
        n = fetch ? 4 : byte_count(op);
        wr = !fetch && is_store_op(op);
        w0 = wr_count;
        lows = 0;
        seen = 0;
        i = 0;
        lat = 0;
        @(posedge clk_in);
        if (fetch) begin
            fetch_req <= '{en: 1'b1, pc: addr};
        end else begin
            ls_req <= '{en: 1'b1, op: op, addr: addr, wdata: wdata};
        end
        if (freeze) begin
            freeze_step(lows);
        end
        while (!seen && i < 64) begin
            @(negedge clk_in);
            if (!freeze && i >= 2 && i < 2 + n) begin
                check_addr("mem_a", mem_a, addr + (i - 2));
                if (wr) begin
                    check_byte("mem_dout", mem_dout, wdata[8*(i-2) +: 8]);
                    if (mem_wr !== 1'b1) begin
                        fail("mem_wr low during a store byte cycle");
                    end
                end
            end
            rsp = fetch ? fetch_rsp : ls_rsp;
            if ((fetch ? ls_rsp.done : fetch_rsp.done) === 1'b1) begin
                fail("done pulse went to the wrong requester");
            end
            if (rsp.done === 1'b1) begin
                seen = 1;
                lat = i;
            end
            @(posedge clk_in);
            i++;
            if (seen) begin
                fetch_req <= '0;
                ls_req    <= '0;
            end
            if (freeze) begin
                if (i < 6 && !seen) begin
                    freeze_step(lows);
                end else begin
                    rdy_in <= 1'b1;
                end
            end
        end
        if (!seen) begin
            fail("no done pulse for the access");
        end else begin
            check_rsp(fetch ? "fetch_rsp" : "ls_rsp", rsp, cpu_pkg::word_rsp_t'{1'b1, exp});
            if (lat != n + (wr ? 2 : 3) + lows) begin
                $display("CHECK FAILED done latency: got %h expected %h",
                         lat, n + (wr ? 2 : 3) + lows);
                errors++;
            end
            if (wr && (wr_count - w0) != n) begin
                $display("CHECK FAILED store byte count: got %h expected %h",
                         wr_count - w0, n);
                errors++;
            end
        end
    endtask

    // fetch and load raised together so the load goes first
    task automatic priority_pair(input cpu_pkg::ls_op_e op, input cpu_pkg::addr_t addr,
                                 input cpu_pkg::addr_t pc, input cpu_pkg::data_t exp_ls,
                                 input cpu_pkg::data_t exp_f);
        int i;
        bit ls_seen;
        bit f_seen;
        i = 0;
        ls_seen = 0;
        f_seen = 0;
        @(posedge clk_in);
        fetch_req <= '{en: 1'b1, pc: pc};
        ls_req    <= '{en: 1'b1, op: op, addr: addr, wdata: '0};
        while (!(ls_seen && f_seen) && i < 80) begin
            @(negedge clk_in);
            if (i == 2) begin
                check_addr("mem_a", mem_a, addr);
            end
            if (ls_rsp.done === 1'b1 && !ls_seen) begin
                ls_seen = 1;
                check_rsp("ls_rsp", ls_rsp, cpu_pkg::word_rsp_t'{1'b1, exp_ls});
                if (f_seen) begin
                    fail("fetch finished before the load");
                end
            end
            if (fetch_rsp.done === 1'b1 && !f_seen) begin
                f_seen = 1;
                check_rsp("fetch_rsp", fetch_rsp, cpu_pkg::word_rsp_t'{1'b1, exp_f});
            end
            @(posedge clk_in);
            i++;
            if (ls_seen) begin
                ls_req <= '0;
            end
            if (f_seen) begin
                fetch_req <= '0;
            end
        end
        if (!(ls_seen && f_seen)) begin
            fail("priority case did not complete both accesses");
        end
    endtask

    // waits for the load/store done while no fetch done may appear
    task automatic wait_ls_done();
        int i;
        bit seen;
        i = 0;
        seen = 0;
        while (!seen && i < 40) begin
            @(negedge clk_in);
            if (fetch_rsp.done === 1'b1) begin
                fail("unexpected fetch done pulse");
            end
            seen = (ls_rsp.done === 1'b1);
            @(posedge clk_in);
            i++;
        end
        ls_req <= '0;
        if (!seen) begin
            fail("store never completed");
        end
    endtask

    task automatic verify_stored_bytes(input cpu_pkg::ls_op_e op, input cpu_pkg::addr_t addr,
                                       input cpu_pkg::data_t wdata);
        cpu_pkg::addr_t a;
        for (int k = 0; k < byte_count(op); k++) begin
            a = addr + k;
            check_byte("ram", ram[a[16:0]], wdata[8*k +: 8]);
        end
    endtask

    task automatic io_stall_store(input cpu_pkg::ls_op_e op, input cpu_pkg::addr_t addr,
                                  input cpu_pkg::data_t wdata);
        @(posedge clk_in);
        io_buffer_full <= 1'b1;
        ls_req         <= '{en: 1'b1, op: op, addr: addr, wdata: wdata};
        repeat (6) begin
            @(negedge clk_in);
            if (mem_wr !== 1'b0) begin
                fail("mem_wr rose while the io buffer was full");
            end
            @(posedge clk_in);
        end
        io_buffer_full <= 1'b0;
        wait_ls_done();
        verify_stored_bytes(op, addr, wdata);
    endtask

    // clr hits a running fetch and stays high while the store runs
    task automatic clr_abort_fetch(input cpu_pkg::ls_op_e op, input cpu_pkg::addr_t addr,
                                   input cpu_pkg::data_t wdata, input cpu_pkg::addr_t pc);
        @(posedge clk_in);
        fetch_req <= '{en: 1'b1, pc: pc};
        repeat (3) @(posedge clk_in);
        clr       <= 1'b1;
        fetch_req <= '0;
        ls_req    <= '{en: 1'b1, op: op, addr: addr, wdata: wdata};
        wait_ls_done();
        clr <= 1'b0;
        repeat (8) begin
            @(negedge clk_in);
            if (fetch_rsp.done === 1'b1) begin
                fail("fetch done pulse after clr");
            end
        end
        verify_stored_bytes(op, addr, wdata);
    endtask

    initial begin
        int fd;
        int n;
        string line;
        cpu_pkg::ls_op_e op;
        rdy_in         = 1'b1;
        clr            = 1'b0;
        io_buffer_full = 1'b0;
        fetch_req      = '0;
        ls_req         = '0;
        mem_din        = '0;
        arst_n         = 1'b0;
        // fill pattern uses all 17 address bits
        for (int a = 0; a < 131072; a++) begin
            ram[a] = a[7:0] ^ a[15:8] ^ {a[16], 7'b0};
        end
        fd = $fopen("mem_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file");
            $display("Errors found");
            $finish;
        end else begin
            while (!$feof(fd) && ncases < 64) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", c_kind[ncases], c_op[ncases],
                                c_addr[ncases], c_wdata[ncases], c_pc[ncases],
                                c_exl[ncases], c_exf[ncases]);
                    if (n == 7) begin
                        ncases++;
                    end
                end
            end
            $fclose(fd);
            cases_loaded = 1'b1;
            if (ncases == 0) begin
                fail("no cases were read from the case file");
            end
            repeat (2) @(posedge clk_in);
            @(negedge clk_in);
            check_addr("mem_a", mem_a, '0);
            if (mem_wr !== 1'b0 || fetch_rsp.done !== 1'b0 || ls_rsp.done !== 1'b0) begin
                fail("outputs not idle during reset");
            end
            @(posedge clk_in);
            arst_n <= 1'b1;
            repeat (2) @(posedge clk_in);
            for (int t = 0; t < ncases; t++) begin
                n = errors;
                op = cpu_pkg::ls_op_e'(c_op[t]);
                case (c_kind[t])
                    0: single_access(1, cpu_pkg::LW, c_pc[t], '0, 0, c_exf[t]);
                    1: single_access(0, op, c_addr[t], c_wdata[t], 0, c_exl[t]);
                    2: priority_pair(op, c_addr[t], c_pc[t], c_exl[t], c_exf[t]);
                    3: single_access(0, op, c_addr[t], c_wdata[t], 1, c_exl[t]);
                    4: single_access(1, cpu_pkg::LW, c_pc[t], '0, 1, c_exf[t]);
                    5: io_stall_store(op, c_addr[t], c_wdata[t]);
                    6: clr_abort_fetch(op, c_addr[t], c_wdata[t], c_pc[t]);
                    default: fail("unknown case kind in the case file");
                endcase
                // idle gap of 1 to 4 cycles
                repeat (1 + {lfsr_bit(), lfsr_bit()}) @(posedge clk_in);
                $display("case %0d kind %0d %s", t, c_kind[t], errors == n ? "passed" : "failed");
            end
            $display("%0d cases run, %0d errors", ncases, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    initial begin
        wait (cases_loaded);
        repeat (ncases * 64) @(posedge clk_in);
        $display("watchdog expired before all cases finished");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_cases.txt
# kind op addr wdata pc exp_ls exp_fetch, all hex
# kinds 0 fetch, 1 load/store, 2 priority, 3 ls freeze, 4 fetch freeze, 5 io stall, 6 clr
0 2 00000000 00000000 00000100 00000000 02030001
0 2 00000000 00000000 00001234 00000000 25242726
1 0 00000085 00000000 00000000 FFFFFF85 00000000
1 3 00000085 00000000 00000000 00000085 00000000
1 1 00000084 00000000 00000000 FFFF8584 00000000
1 4 00000084 00000000 00000000 00008584 00000000
1 2 00000080 00000000 00000000 83828180 00000000
1 0 00000142 00000000 00000000 00000043 00000000
1 1 00010010 00000000 00000000 FFFF9190 00000000
1 5 00000200 AABBCCDD 00000000 00000000 00000000
1 2 00000200 00000000 00000000 010003DD 00000000
1 6 00000302 12345678 00000000 00000000 00000000
1 2 00000300 00000000 00000000 56780203 00000000
1 7 00000404 CAFEF00D 00000000 00000000 00000000
1 2 00000404 00000000 00000000 CAFEF00D 00000000
2 2 00000080 00000000 00000100 83828180 02030001
3 2 00000080 00000000 00000000 83828180 00000000
3 2 00000400 00000000 00000000 07060504 00000000
3 2 00000404 00000000 00000000 CAFEF00D 00000000
4 2 00000000 00000000 00001234 00000000 25242726
4 2 00000000 00000000 00000100 00000000 02030001
5 5 00030000 000000A5 00000000 00000000 00000000
5 7 00030010 11223344 00000000 00000000 00000000
6 5 00000500 0000005A 00001234 00000000 00000000
6 6 00000600 0000BEEF 00000100 00000000 00000000

//--- files.f
cpu_pkg.sv
mem_sched.sv
byte_seq.sv
load_align.sv
memctrl.sv
tb_memctrl.sv
